// File: compile.f
rtl/scene_pkg.sv
rtl/xmodem_receiver.sv
rtl/seg_base_regs.sv
rtl/scene_loader.sv
rtl/scene_loader_top.sv
testbench/scene_loader_asserts.sv
testbench/scene_loader_tb.sv

// File: rtl/scene_loader.sv
module scene_loader #(
    parameter int num_segments = 3  // 3 without colors/normals, 4 with
) (
    input  logic                       clk,
    input  logic                       reset,
    input  scene_pkg::xm_events_t      events,
    input  scene_pkg::mem_addr_t [3:0] seg_base,
    output scene_pkg::mem_addr_t       mem_addr,
    output scene_pkg::mem_word_t       mem_data,
    output logic                       mem_we,
    output logic                       load_done
);
    import scene_pkg::*;

    localparam seg_type_t last_seg = seg_type_t'(num_segments - 1);

    localparam loader_state_t init_state = '{
        getting_size: 1'b1,
        current_seg:  kdtree,
        seg_size:     '0,
        seg_offset:   '0
    };

    loader_state_t cs, good_ns, ns;
    loader_state_t checkpoint;
    logic [6:0]    byte_cnt, byte_cnt_ckpt, byte_cnt_next;
    xm_byte_t      data_reg0, data_reg1, data_reg2;
    mem_word_t     word;
    logic          word_ready;
    logic          segment_done;
    logic          repeat_flag;
    logic          save, restore;
    logic          done_seen;

    // big-endian, the incoming byte is the lsb
    assign word       = {data_reg0, data_reg1, data_reg2, events.data};
    assign word_ready = events.msg_byte_valid && (byte_cnt[1:0] == 2'd3);

    assign segment_done = !cs.getting_size && (cs.seg_offset == cs.seg_size);

    assign mem_we   = word_ready && !cs.getting_size;  // size words are not stored
    assign mem_data = word;
    assign mem_addr = seg_base[cs.current_seg] + cs.seg_offset;

    assign load_done = events.done || done_seen;

    always_ff @(posedge clk) begin
        if (events.msg_byte_valid) begin
            case (byte_cnt[1:0])
                2'd0:    data_reg0 <= events.data;
                2'd1:    data_reg1 <= events.data;
                2'd2:    data_reg2 <= events.data;
                default: ;  // byte 3 goes straight to the word
            endcase
        end
    end

    always_comb begin
        good_ns = cs;
        if (cs.getting_size) begin
            if (word_ready) begin
                good_ns.getting_size = 1'b0;
                good_ns.seg_size     = word[24:0];
                good_ns.seg_offset   = '0;
            end
        end else if (segment_done) begin
            good_ns.getting_size = 1'b1;
            good_ns.seg_offset   = '0;
            if (cs.current_seg == last_seg) begin
                good_ns.current_seg = kdtree;  // next scene starts over
            end else begin
                good_ns.current_seg = seg_type_t'(cs.current_seg + 2'd1);
            end
        end else if (word_ready) begin
            good_ns.seg_offset = cs.seg_offset + 25'd1;
        end
    end

    // a resent block is checked against the checkpoint, not taken as new
    assign save    = events.valid_block && !repeat_flag;
    assign restore = events.invalid_block || (events.valid_block && repeat_flag);

    assign ns            = restore ? checkpoint : good_ns;
    assign byte_cnt_next = restore ? byte_cnt_ckpt :
                           events.msg_byte_valid ? byte_cnt + 7'd1 : byte_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cs            <= init_state;
            checkpoint    <= init_state;
            byte_cnt      <= '0;
            byte_cnt_ckpt <= '0;
            repeat_flag   <= 1'b0;
            done_seen     <= 1'b0;
        end else begin
            cs       <= ns;
            byte_cnt <= byte_cnt_next;
            if (save) begin
                checkpoint    <= cs;
                byte_cnt_ckpt <= byte_cnt;  // keeps partial words aligned
            end
            if (events.valid_block || events.invalid_block) begin
                repeat_flag <= 1'b0;
            end else if (events.repeat_block) begin
                repeat_flag <= 1'b1;
            end
            if (events.done) begin
                done_seen <= 1'b1;
            end
        end
    end

endmodule

// File: rtl/scene_loader_top.sv
module scene_loader_top #(
    parameter int                         num_segments = 3,
    parameter scene_pkg::mem_addr_t [3:0] reset_base   = {
        25'h0180000,  // colors_norms
        25'h0100000,  // uttm
        25'h0080000,  // lists
        25'h0000000   // kdtree
    }
) (
    input  logic                 clk,
    input  logic                 reset,
    input  scene_pkg::xm_byte_t  rx_byte,
    input  logic                 rx_valid,
    output scene_pkg::xm_byte_t  tx_byte,
    output logic                 tx_valid,
    input  scene_pkg::cfg_req_t  cfg,
    input  logic                 cfg_req,
    output logic                 cfg_ack,
    output scene_pkg::mem_addr_t mem_addr,
    output scene_pkg::mem_word_t mem_data,
    output logic                 mem_we,
    output logic                 load_done
);
    import scene_pkg::*;

    xm_events_t      events;    // receiver strobes, registered
    mem_addr_t [3:0] seg_base;

    xmodem_receiver i_xmodem_receiver (
        .clk      (clk),
        .reset    (reset),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .events   (events),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid)
    );

    seg_base_regs #(
        .reset_base (reset_base)
    ) i_seg_base_regs (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .cfg_req  (cfg_req),
        .cfg_ack  (cfg_ack),
        .seg_base (seg_base)
    );

    scene_loader #(
        .num_segments (num_segments)
    ) i_scene_loader (
        .clk       (clk),
        .reset     (reset),
        .events    (events),
        .seg_base  (seg_base),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .mem_we    (mem_we),
        .load_done (load_done)
    );

endmodule

// File: rtl/scene_pkg.sv
package scene_pkg;

    typedef logic [7:0]  xm_byte_t;   // one byte on the serial link
    typedef logic [24:0] mem_addr_t;  // sdram word address
    typedef logic [31:0] mem_word_t;  // sdram data word
    typedef logic [24:0] seg_size_t;  // segment length in words

    // scene segments in load order
    typedef enum logic [1:0] {
        kdtree,
        lists,
        uttm,
        colors_norms
    } seg_type_t;

    // loader state, this is what gets checkpointed
    typedef struct packed {
        logic      getting_size;
        seg_type_t current_seg;
        seg_size_t seg_size;
        seg_size_t seg_offset;
    } loader_state_t;

    typedef struct packed {
        seg_type_t seg;   // which base register
        mem_addr_t base;
    } cfg_req_t;

    // one-cycle strobes from the receiver
    typedef struct packed {
        logic     msg_byte_valid;
        logic     valid_block;
        logic     invalid_block;
        logic     repeat_block;
        logic     done;
        xm_byte_t data;
    } xm_events_t;

    localparam xm_byte_t xm_soh = 8'h01;
    localparam xm_byte_t xm_eot = 8'h04;
    localparam xm_byte_t xm_ack = 8'h06;
    localparam xm_byte_t xm_nak = 8'h15;
    localparam int       block_len = 128;

endpackage

// File: rtl/seg_base_regs.sv
module seg_base_regs #(
    parameter scene_pkg::mem_addr_t [3:0] reset_base = '0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  scene_pkg::cfg_req_t        cfg,
    input  logic                       cfg_req,
    output logic                       cfg_ack,
    output scene_pkg::mem_addr_t [3:0] seg_base
);

    logic do_write;

    // write only in the first cycle of a request, before the ack is up
    assign do_write = cfg_req && !cfg_ack;

    // one base register per segment, indexed by the segment enum
    always_ff @(posedge clk) begin
        if (reset) begin
            seg_base <= reset_base;
        end else if (do_write) begin
            seg_base[cfg.seg] <= cfg.base;
        end
    end

    // four-phase handshake
    // req up   -> write, ack up next cycle
    // req down -> ack down next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_ack <= 1'b0;
        end else begin
            cfg_ack <= cfg_req;
        end
    end

endmodule

// File: rtl/xmodem_receiver.sv
module xmodem_receiver (
    input  logic                  clk,
    input  logic                  reset,
    input  scene_pkg::xm_byte_t   rx_byte,
    input  logic                  rx_valid,
    output scene_pkg::xm_events_t events,
    output scene_pkg::xm_byte_t   tx_byte,
    output logic                  tx_valid
);
    import scene_pkg::*;

    typedef enum logic [2:0] {
        idle,
        blk_num,
        blk_inv,
        data,
        checksum,
        finished
    } rx_state_t;

    rx_state_t  state;
    xm_byte_t   cur_blk;    // block number of the block in flight
    xm_byte_t   last_good;  // number of the last block that was acked
    xm_byte_t   next_blk;
    xm_byte_t   sum;
    logic [6:0] data_cnt;
    logic       hdr_err;    // sticky over the block
    logic       in_repeat;
    logic       sum_ok;

    assign next_blk = last_good + 8'd1;

    // a block with a bad header is refused whatever its checksum
    assign sum_ok = (rx_byte == sum) && !hdr_err;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= idle;
            last_good <= '0;
            hdr_err   <= 1'b0;
            in_repeat <= 1'b0;
            data_cnt  <= '0;
            events    <= '0;
            tx_valid  <= 1'b0;
        end else begin
            events   <= '0;     // strobes last one cycle
            tx_valid <= 1'b0;
            if (rx_valid) begin
                case (state)
                    idle: begin
                        if (rx_byte == xm_soh) begin
                            state <= blk_num;
                        end else if (rx_byte == xm_eot) begin
                            state       <= finished;
                            events.done <= 1'b1;
                            tx_byte     <= xm_ack;  // eot is acked as well
                            tx_valid    <= 1'b1;
                        end
                    end
                    blk_num: begin
                        cur_blk   <= rx_byte;
                        in_repeat <= (rx_byte == last_good);
                        // neither the next block nor a resend of the last one
                        hdr_err   <= (rx_byte != next_blk) && (rx_byte != last_good);
                        events.repeat_block <= (rx_byte == last_good);
                        state <= blk_inv;
                    end
                    blk_inv: begin
                        if (rx_byte != ~cur_blk) begin
                            hdr_err <= 1'b1;
                        end
                        sum      <= '0;
                        data_cnt <= '0;
                        state    <= data;
                    end
                    data: begin
                        sum      <= sum + rx_byte;  // checksum is mod 256
                        data_cnt <= data_cnt + 7'd1;
                        // bytes of a resend or of a broken header stay here
                        events.msg_byte_valid <= !hdr_err && !in_repeat;
                        events.data <= rx_byte;
                        if (data_cnt == 7'(block_len - 1)) begin
                            state <= checksum;
                        end
                    end
                    checksum: begin
                        events.valid_block   <= sum_ok;
                        events.invalid_block <= !sum_ok;
                        tx_byte  <= sum_ok ? xm_ack : xm_nak;
                        tx_valid <= 1'b1;
                        if (sum_ok) begin
                            last_good <= cur_blk;
                        end
                        state <= idle;
                    end
                    finished: begin
                        state <= finished;  // held until reset
                    end
                    default: begin
                        state <= idle;
                    end
                endcase
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the scene loader testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module scene_loader_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vscene_loader_tb 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: testbench/scene_loader_asserts.sv
module scene_loader_asserts (
    input logic                       clk,
    input logic                       reset,
    input logic                       mem_we,
    input scene_pkg::loader_state_t   state,
    input logic                       repeat_flag,
    input scene_pkg::cfg_req_t        cfg,
    input logic                       cfg_req,
    input logic                       cfg_ack,
    input scene_pkg::mem_addr_t [3:0] seg_base
);
    timeunit 1ns;
    timeprecision 1ps;

    // size words are never stored and data stays inside its segment
    no_write_in_size: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> !state.getting_size && (state.seg_offset < state.seg_size))
        else $error("mem_we while the loader expects a size word or past the segment end");

    // bytes of a resent block never reach memory
    no_write_in_repeat: assert property (@(posedge clk) disable iff (reset)
        repeat_flag |-> !mem_we)
        else $error("mem_we during a repeated block");

    ack_after_write: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_ack) |-> $past(cfg_req) && (seg_base[$past(cfg.seg)] == $past(cfg.base)))
        else $error("cfg_ack rose without a request or without the base written");

endmodule

bind scene_loader_top scene_loader_asserts i_scene_loader_asserts (
    .clk         (clk),
    .reset       (reset),
    .mem_we      (mem_we),
    .state       (i_scene_loader.cs),
    .repeat_flag (i_scene_loader.repeat_flag),
    .cfg         (cfg),
    .cfg_req     (cfg_req),
    .cfg_ack     (cfg_ack),
    .seg_base    (seg_base)
);

// File: testbench/scene_loader_tb.sv
module scene_loader_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import scene_pkg::*;

    localparam int clk_period = 100;
    localparam int byte_gap   = 4;  // clock cycles from one link byte to the next
    localparam int n_blocks   = 4;
    localparam int n_segs     = 3;  // top level default
    localparam int n_tests    = 7;

    typedef enum logic [1:0] {cor_none, cor_sum, cor_inv, cor_repeat} corrupt_t;

    typedef struct packed {
        xm_byte_t blk;
        corrupt_t kind;
        xm_byte_t reply;  // expected answer on tx
    } test_t;

    localparam test_t tests [n_tests] = '{
        '{8'd1, cor_none,   xm_ack},
        '{8'd2, cor_sum,    xm_nak},
        '{8'd2, cor_none,   xm_ack},
        '{8'd2, cor_repeat, xm_ack},
        '{8'd3, cor_inv,    xm_nak},
        '{8'd3, cor_none,   xm_ack},
        '{8'd4, cor_none,   xm_ack}
    };
    string names [n_tests] = '{"clean 1", "bad checksum 2", "resend 2", "duplicate 2",
                               "bad complement 3", "resend 3", "clean 4"};

    // kdtree, lists, uttm, then the scene wraps to kdtree
    localparam mem_word_t size_tab [5] = '{40, 37, 30, 16, 5};
    localparam mem_addr_t new_base [n_segs] = '{25'h0040000, 25'h0123400, 25'h1f00000};

    logic      clk = 1'b0;
    logic      reset, rx_valid, tx_valid, cfg_req, cfg_ack, mem_we, load_done;
    xm_byte_t  rx_byte, tx_byte;
    cfg_req_t  cfg;
    mem_addr_t mem_addr;
    mem_word_t mem_data;

    xm_byte_t  payload [n_blocks * block_len];
    mem_word_t mem_img [mem_addr_t];  // dut writes, last one wins
    mem_word_t exp_img [mem_addr_t];
    xm_byte_t  tx_q [$];
    int        ack_cnt = 0;
    int        we_cnt = 0;  // memory writes seen so far
    logic      ack_d = 1'b0;

    // reference loader state
    logic      m_getting_size = 1'b1;
    int        m_seg = 0;
    int        m_bytes = 0;
    seg_size_t m_size = '0;
    seg_size_t m_offset = '0;
    mem_word_t m_word = '0;

    scene_loader_top i_scene_loader_top (.*);

    initial begin
        forever #(clk_period / 2) clk = ~clk;
    end

    // dut outputs are stable on the falling edge
    always @(negedge clk) begin
        if (mem_we) begin
            mem_img[mem_addr] = mem_data;
            we_cnt++;
        end
        if (tx_valid) begin
            tx_q.push_back(tx_byte);
        end
        if (cfg_ack && !ack_d) begin
            ack_cnt++;
        end
        ack_d = cfg_ack;
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_byte(string name, xm_byte_t exp, xm_byte_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_word(string name, mem_word_t exp, mem_word_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_addr(string name, mem_addr_t exp, mem_addr_t act);
        if (act !== exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (act != exp) begin
            stop_on_error($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic send_byte(xm_byte_t b);
        @(negedge clk);
        rx_byte  = b;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        repeat (byte_gap - 2) @(negedge clk);
    endtask

    task automatic send_block(test_t t);
        xm_byte_t sum;
        int       base;
        sum  = '0;
        base = (int'(t.blk) - 1) * block_len;
        for (int i = 0; i < block_len; i++) begin
            sum = sum + payload[base + i];  // checksum of the clean data
        end
        send_byte(xm_soh);
        send_byte(t.blk);
        send_byte(t.kind == cor_inv ? t.blk : ~t.blk);
        for (int i = 0; i < block_len; i++) begin
            // byte 5 of block 2 sits in a data word
            send_byte((t.kind == cor_sum && i == 5) ? ~payload[base + i] : payload[base + i]);
        end
        send_byte(sum);
    endtask

    task automatic check_reply(string name, xm_byte_t exp);
        while (tx_q.size() == 0) begin
            @(negedge clk);
        end
        compare_byte(name, exp, tx_q.pop_front());
    endtask

    // four-phase write of one base register
    task automatic write_base(seg_type_t seg, mem_addr_t base);
        @(negedge clk);
        cfg     = '{seg: seg, base: base};
        cfg_req = 1'b1;
        while (!cfg_ack) begin
            @(negedge clk);
        end
        cfg_req = 1'b0;
        while (cfg_ack) begin
            @(negedge clk);
        end
    endtask

    // segment rules applied to one accepted block
    task automatic model_block(xm_byte_t blk);
        for (int i = 0; i < block_len; i++) begin
            m_word = {m_word[23:0], payload[(int'(blk) - 1) * block_len + i]};
            m_bytes++;
            if (m_bytes % 4 == 0) begin
                if (m_getting_size) begin
                    m_size         = m_word[24:0];
                    m_offset       = '0;
                    m_getting_size = 1'b0;
                end else begin
                    exp_img[new_base[m_seg] + m_offset] = m_word;
                    m_offset++;
                end
                if (!m_getting_size && m_offset == m_size) begin
                    m_getting_size = 1'b1;
                    m_seg          = (m_seg + 1) % n_segs;
                end
            end
        end
    endtask

    initial begin
        int        hdr;
        int        k;
        int        we_before;
        mem_word_t word;
        mem_addr_t ka, kb;

        void'($urandom(32'h0e045150));
        reset    = 1'b1;
        rx_valid = 1'b0;
        rx_byte  = '0;
        cfg_req  = 1'b0;
        cfg      = '0;
        hdr      = 0;
        k        = 0;
        for (int w = 0; w < n_blocks * block_len / 4; w++) begin
            if (w == hdr) begin
                word = size_tab[k];
                hdr  = w + 1 + int'(size_tab[k]);
                k++;
            end else begin
                word = $urandom;
            end
            {payload[4*w], payload[4*w+1], payload[4*w+2], payload[4*w+3]} = word;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if ({tx_valid, mem_we, cfg_ack, load_done} !== 4'b0000) begin
            stop_on_error("outputs were not low after reset");
        end

        for (int s = 0; s < n_segs; s++) begin
            write_base(seg_type_t'(s), new_base[s]);
        end
        compare_count("cfg acks", n_segs, ack_cnt);

        for (int i = 0; i < n_tests; i++) begin
            we_before = we_cnt;
            send_block(tests[i]);
            check_reply(names[i], tests[i].reply);
            if (tests[i].kind == cor_repeat) begin
                // a duplicate leaves memory untouched
                compare_count({names[i], " writes"}, we_before, we_cnt);
            end
            if (tests[i].kind == cor_none) begin
                model_block(tests[i].blk);
            end
        end

        send_byte(xm_eot);
        check_reply("eot", xm_ack);
        if (!load_done) begin
            stop_on_error("load_done did not rise after EOT");
        end
        repeat (10) @(negedge clk);
        if (!load_done) begin
            stop_on_error("load_done fell again before reset");
        end

        compare_count("image size", exp_img.num(), mem_img.num());
        void'(exp_img.first(ka));
        void'(mem_img.first(kb));
        for (int i = 0; i < exp_img.num(); i++) begin
            compare_addr("image address", ka, kb);
            compare_word($sformatf("word at %h", ka), exp_img[ka], mem_img[kb]);
            void'(exp_img.next(ka));
            void'(mem_img.next(kb));
        end
        $display("Everything OK");
        $finish;
    end

    // every table entry is one block of about 132 link bytes
    initial begin
        #(n_tests * 140 * byte_gap * clk_period * 2);
        $display("timeout, the load did not finish in time");
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

endmodule
